// File: bench/lab_board_vectors.txt
// columns: sw_ledr_seg0_seg1 in hex, one test step per line
// alu: sw[3:0] a, sw[7:4] b, sw[10:8] op; ledr {result, 0, carry, ovfl, zero}
0017_0082_a4_80
0118_0076_82_f8
001f_0005_92_c0
0155_0005_92_c0
0152_00d0_c0_a1
0205_00a0_c0_88
03ac_0080_c0_80
04a5_00f0_c0_8e
0536_0050_c0_92
061e_0010_c0_f9
0693_0001_f9_c0
0799_0010_c0_f9
0789_0001_f9_c0
// shifter on din 96
4c96_002c_c6_a4
6496_0060_c0_82
7c96_0000_c0_c0
4896_004b_83_99
6096_0009_90_c0
7896_0001_f9_c0
4296_0096_82_90
4a96_00cb_83_c6
6296_00f9_90_8e
7a96_00ff_8e_8e
// encoder
8050_0000_c0_c0
8100_0000_c0_c0
8108_0013_b0_f9
8125_0015_92_f9
8181_0017_f8_f9
// random, one alu step in between
c000_0001_f9_c0
c0ff_0080_c0_80
c123_0040_c0_99
c000_0020_c0_a4
c000_0010_c0_f9
0043_0070_c0_f8
c000_0088_80_80
c000_00c4_99_c6

// File: lab_board.f
rtl/lab_pkg.sv
rtl/lab_alu.sv
rtl/barrel_shifter.sv
rtl/priority_encoder.sv
rtl/lfsr_random.sv
rtl/hex_segment.sv
rtl/lab_board.sv
bench/lab_board_properties.sv
bench/lab_board_tb.sv

// File: Bender.yml
package:
  name: lab_board

sources:
  - files:
      - rtl/lab_pkg.sv
      - rtl/lab_alu.sv
      - rtl/barrel_shifter.sv
      - rtl/priority_encoder.sv
      - rtl/lfsr_random.sv
      - rtl/hex_segment.sv
      - rtl/lab_board.sv
  - target: test
    files:
      - bench/lab_board_properties.sv
      - bench/lab_board_tb.sv

// File: bench/lab_board_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lab_board_tb import lab_pkg::*; ();

    localparam int    clk_period  = 40;
    localparam int    max_vectors = 64;
    localparam string vec_path    = "bench/lab_board_vectors.txt";

    // one line of the vectors file
    typedef struct packed {
        logic [15:0] sw;
        logic [15:0] ledr;
        logic [7:0]  seg0;
        logic [7:0]  seg1;
    } vector_t;

    logic        btn;
    logic        arst_n;
    logic [15:0] sw;
    logic [15:0] ledr;
    logic [7:0]  seg0;
    logic [7:0]  seg1;

    logic [47:0] vec_mem [max_vectors];
    int          vec_count;
    bit          vectors_ready;
    int          check_errors;
    int          file_errors;

    lab_board dut (
        .btn    (btn),
        .arst_n (arst_n),
        .sw     (sw),
        .ledr   (ledr),
        .seg0   (seg0),
        .seg1   (seg1)
    );

    initial begin
        btn = 1'b0;
        forever #(clk_period / 2) btn = ~btn;
    end

    task automatic load_vectors();
        int      fd;
        vector_t v;
        // all ones marks unused entries, real ledr never has its top byte set
        for (int i = 0; i < max_vectors; i++) begin
            vec_mem[i] = '1;
        end
        fd = $fopen(vec_path, "r");
        if (fd == 0) begin
            $display("cannot open the vectors file %s", vec_path);
            file_errors++;
        end else begin
            $fclose(fd);
            $readmemh(vec_path, vec_mem);
            vec_count = 0;
            for (int i = 0; i < max_vectors; i++) begin
                v = vector_t'(vec_mem[i]);
                if (v.ledr == 16'hffff) begin
                    break;
                end
                vec_count++;
            end
            if (vec_count == 0) begin
                $display("the vectors file %s holds no vectors", vec_path);
                file_errors++;
            end
        end
    endtask

    task automatic check_outputs(
        input string       step,
        input logic [15:0] exp_ledr,
        input logic [7:0]  exp_seg0,
        input logic [7:0]  exp_seg1
    );
        assert (ledr === exp_ledr) else begin
            check_errors++;
            $display("Mismatch at %0t: %s ledr %h, expected %h", $time, step, ledr, exp_ledr);
        end
        assert (seg0 === exp_seg0) else begin
            check_errors++;
            $display("Mismatch at %0t: %s seg0 %h, expected %h", $time, step, seg0, exp_seg0);
        end
        assert (seg1 === exp_seg1) else begin
            check_errors++;
            $display("Mismatch at %0t: %s seg1 %h, expected %h", $time, step, seg1, exp_seg1);
        end
    endtask

    initial begin
        wait (vectors_ready);
        #((vec_count + 10) * clk_period);
        $display("timeout: the run did not finish within %0d cycles", vec_count + 10);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        vector_t cur;
        vector_t prev;
        void'($urandom(74));
        arst_n        = 1'b0;
        sw            = 16'h0000;
        vec_count     = 0;
        check_errors  = 0;
        file_errors   = 0;
        vectors_ready = 1'b0;
        load_vectors();
        vectors_ready = 1'b1;

        // upper switch bits are free while reset holds the display
        repeat (3) begin
            @(posedge btn);
            sw <= {8'($urandom), 8'h00};
        end

        if (file_errors == 0) begin
            // vector i goes in at edge i and is checked after edge i+1
            for (int i = 0; i <= vec_count; i++) begin
                @(posedge btn);
                if (i == 0) begin
                    arst_n <= 1'b1;
                end
                if (i < vec_count) begin
                    cur = vector_t'(vec_mem[i]);
                    sw <= cur.sw;
                end
                @(negedge btn);
                if (i == 0) begin
                    check_outputs("after reset", 16'h0000, seg_blank, seg_blank);
                end else begin
                    prev = vector_t'(vec_mem[i - 1]);
                    check_outputs($sformatf("vector %0d", i - 1), prev.ledr, prev.seg0,
                        prev.seg1);
                end
            end
        end

        $display("done: %0d mismatches, %0d file errors, %0d assertion failures",
            check_errors, file_errors, dut.u_props.fail_count);
        if (check_errors + file_errors + dut.u_props.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/lab_board_properties.sv
`timescale 1ns/10ps
`default_nettype none

module lab_board_properties (
    input logic        btn,
    input logic        arst_n,
    input logic [15:0] ledr,
    input logic [7:0]  seg0
);

    int fail_count = 0;

    // display register cleared while reset is held
    reset_clears_leds: assert property (@(posedge btn) !arst_n |-> ledr == 16'h0000)
        else begin
            fail_count++;
            $error("ledr not zero while reset is asserted");
        end

    upper_leds_dark: assert property (@(posedge btn) ledr[15:8] == 8'h00)
        else begin
            fail_count++;
            $error("ledr upper byte is not zero");
        end

    // dp is active low and never lit
    seg0_dp_off: assert property (@(posedge btn) seg0[7] == 1'b1)
        else begin
            fail_count++;
            $error("seg0 decimal point is lit");
        end

endmodule

bind lab_board lab_board_properties u_props (
    .btn    (btn),
    .arst_n (arst_n),
    .ledr   (ledr),
    .seg0   (seg0)
);

`default_nettype wire

// File: rtl/lab_board.sv
`timescale 1ns/10ps
`default_nettype none

module lab_board import lab_pkg::*; (
    input  logic        btn,
    input  logic        arst_n,
    input  logic [15:0] sw,
    output logic [15:0] ledr,
    output logic [7:0]  seg0,
    output logic [7:0]  seg1
);

    lab_mode_e      mode;
    alu_op_e        alu_op;
    alu_result_t    alu_res;
    shift_req_t     shift_req;
    logic [7:0]     shift_out;
    encode_result_t enc_res;
    logic           rnd_en;
    logic [7:0]     rnd_next;

    logic [7:0]     disp_d;
    logic [7:0]     disp_q;
    logic           disp_vld;
    logic [7:0]     seg_lo;
    logic [7:0]     seg_hi;

    // switch fields
    assign mode   = lab_mode_e'(sw[15:14]);
    assign alu_op = alu_op_e'(sw[10:8]);
    assign rnd_en = (mode == mode_random);

    assign shift_req = '{
        din:   sw[7:0],
        shamt: sw[13:11],
        lr:    sw[10],
        al:    sw[9]
    };

    lab_alu u_alu (
        .a      (sw[3:0]),
        .b      (sw[7:4]),
        .op     (alu_op),
        .result (alu_res)
    );

    barrel_shifter u_shifter (
        .req  (shift_req),
        .dout (shift_out)
    );

    priority_encoder u_encoder (
        .src    (sw[7:0]),
        .en     (sw[8]),
        .result (enc_res)
    );

    // held while another experiment is shown
    lfsr_random u_random (
        .btn        (btn),
        .arst_n     (arst_n),
        .en         (rnd_en),
        .state      (),
        .state_next (rnd_next)
    );

    always_comb begin
        unique case (mode)
            mode_alu: begin
                disp_d = {alu_res.result, 1'b0, alu_res.carry, alu_res.ovfl, alu_res.zero};
            end
            mode_shift: begin
                disp_d = shift_out;
            end
            mode_encode: begin
                disp_d = {3'b000, enc_res.valid, 1'b0, enc_res.index};
            end
            mode_random: begin
                // same edge loads the generator, so show its next value
                disp_d = rnd_next;
            end
            default: begin
                disp_d = 8'h00;
            end
        endcase
    end

    always_ff @(posedge btn or negedge arst_n) begin
        if (!arst_n) begin
            disp_q   <= 8'h00;
            disp_vld <= 1'b0;
        end else begin
            disp_q   <= disp_d;
            disp_vld <= 1'b1;
        end
    end

    hex_segment u_seg_lo (
        .num (disp_q[3:0]),
        .led (seg_lo)
    );

    hex_segment u_seg_hi (
        .num (disp_q[7:4]),
        .led (seg_hi)
    );

    // digits dark until the first edge
    assign ledr = {8'h00, disp_q};
    assign seg0 = disp_vld ? seg_lo : seg_blank;
    assign seg1 = disp_vld ? seg_hi : seg_blank;

endmodule

`default_nettype wire

// File: rtl/hex_segment.sv
`timescale 1ns/10ps
`default_nettype none

module hex_segment (
    input  logic [3:0] num,
    output logic [7:0] led
);

    // active low, bit 7 is the dp and stays high
    always_comb begin
        unique case (num)
            4'h0: led = 8'hc0;
            4'h1: led = 8'hf9;
            4'h2: led = 8'ha4;
            4'h3: led = 8'hb0;
            4'h4: led = 8'h99;
            4'h5: led = 8'h92;
            4'h6: led = 8'h82;
            4'h7: led = 8'hf8;
            4'h8: led = 8'h80;
            4'h9: led = 8'h90;
            4'ha: led = 8'h88;
            4'hb: led = 8'h83;
            4'hc: led = 8'hc6;
            4'hd: led = 8'ha1;
            4'he: led = 8'h86;
            4'hf: led = 8'h8e;
            default: led = 8'hff;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/lfsr_random.sv
`timescale 1ns/10ps
`default_nettype none

module lfsr_random import lab_pkg::*; (
    input  logic       btn,
    input  logic       arst_n,
    input  logic       en,
    output logic [7:0] state,
    output logic [7:0] state_next
);

    logic feedback;

    // taps 4,3,2,0 shifted in at the top
    assign feedback = state[4] ^ state[3] ^ state[2] ^ state[0];

    always_comb begin
        if (state == 8'h00) begin
            state_next = lfsr_seed;
        end else begin
            state_next = {feedback, state[7:1]};
        end
    end

    always_ff @(posedge btn or negedge arst_n) begin
        if (!arst_n) begin
            state <= 8'h00;
        end else if (en) begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/priority_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module priority_encoder import lab_pkg::*; (
    input  logic [7:0]     src,
    input  logic           en,
    output encode_result_t result
);

    logic [2:0] top_bit;
    logic       any_set;

    assign any_set = |src;

    // last hit wins, so the highest set bit decides
    always_comb begin
        top_bit = 3'd0;
        for (int i = 0; i < 8; i++) begin
            if (src[i]) begin
                top_bit = 3'(i);
            end
        end
    end

    always_comb begin
        result.valid = en & any_set;
        result.index = result.valid ? top_bit : 3'd0;
    end

endmodule

`default_nettype wire

// File: rtl/barrel_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module barrel_shifter import lab_pkg::*; (
    input  shift_req_t req,
    output logic [7:0] dout
);

    logic       fill;
    logic [7:0] stage1;
    logic [7:0] stage2;
    logic [7:0] stage4;

    // sign fill only on arithmetic right shifts
    assign fill = ~req.lr & req.al & req.din[7];

    always_comb begin
        stage1 = req.din;
        if (req.shamt[0]) begin
            stage1 = req.lr ? {req.din[6:0], 1'b0} : {fill, req.din[7:1]};
        end

        stage2 = stage1;
        if (req.shamt[1]) begin
            stage2 = req.lr ? {stage1[5:0], 2'b00} : {{2{fill}}, stage1[7:2]};
        end

        stage4 = stage2;
        if (req.shamt[2]) begin
            stage4 = req.lr ? {stage2[3:0], 4'h0} : {{4{fill}}, stage2[7:4]};
        end
    end

    assign dout = stage4;

endmodule

`default_nettype wire

// File: rtl/lab_alu.sv
`timescale 1ns/10ps
`default_nettype none

module lab_alu import lab_pkg::*; (
    input  logic [3:0]  a,
    input  logic [3:0]  b,
    input  alu_op_e     op,
    output alu_result_t result
);

    logic [4:0] add_sum;
    logic [4:0] sub_sum;
    logic [3:0] b_inv;
    logic       add_ovfl;
    logic       sub_ovfl;

    assign b_inv = ~b;

    // both paths one bit wider to catch the carry
    assign add_sum = {1'b0, a} + {1'b0, b};
    assign sub_sum = {1'b0, a} + {1'b0, b_inv} + 5'd1;

    // same operand signs, result sign flipped
    assign add_ovfl = (a[3] == b[3]) && (add_sum[3] != a[3]);
    assign sub_ovfl = (a[3] == b_inv[3]) && (sub_sum[3] != a[3]);

    always_comb begin
        result = '0;
        unique case (op)
            op_add: begin
                result.result = add_sum[3:0];
                result.carry  = add_sum[4];
                result.ovfl   = add_ovfl;
            end
            op_sub: begin
                result.result = sub_sum[3:0];
                result.carry  = sub_sum[4];
                result.ovfl   = sub_ovfl;
            end
            op_not: begin
                result.result = ~a;
            end
            op_and: begin
                result.result = a & b;
            end
            op_or: begin
                result.result = a | b;
            end
            op_xor: begin
                result.result = a ^ b;
            end
            op_lt: begin
                // signed compare
                result.result = ($signed(a) < $signed(b)) ? 4'd1 : 4'd0;
            end
            op_eq: begin
                result.result = (a == b) ? 4'd1 : 4'd0;
            end
            default: begin
                result.result = 4'd0;
            end
        endcase
        result.zero = (result.result == 4'd0);
    end

endmodule

`default_nettype wire

// File: rtl/lab_pkg.sv
`default_nettype none

package lab_pkg;

    // experiment picked by sw[15:14]
    typedef enum logic [1:0] {
        mode_alu    = 2'd0,
        mode_shift  = 2'd1,
        mode_encode = 2'd2,
        mode_random = 2'd3
    } lab_mode_e;

    // alu opcodes on sw[10:8]
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_not = 3'd2,
        op_and = 3'd3,
        op_or  = 3'd4,
        op_xor = 3'd5,
        op_lt  = 3'd6,
        op_eq  = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic [3:0] result;
        logic       zero;
        logic       ovfl;
        logic       carry;
    } alu_result_t;

    typedef struct packed {
        logic [7:0] din;
        logic [2:0] shamt;
        logic       lr;     // 1 = left
        logic       al;     // 1 = arithmetic
    } shift_req_t;

    typedef struct packed {
        logic [2:0] index;
        logic       valid;
    } encode_result_t;

    // active low, every segment and dp dark
    localparam logic [7:0] seg_blank = 8'hff;

    // reload value when the generator state is all zeros
    localparam logic [7:0] lfsr_seed = 8'h01;

endpackage

`default_nettype wire
